//--- source/acp_mem_pkg.sv
// ACP memory slave shared definitions
// Bus and memory widths, access latency, burst FSM encoding and the
// positions of the control fields on ctrl_in and ctrl_out

package acp_mem_pkg;

    // Host bus widths
    localparam int BUS_W  = 32;
    localparam int CTRL_W = 8;

    // Word memory of 64 entries
    localparam int MEM_ADDR_W = 6;

    // Cycles spent in a wait state ahead of the data phase
    localparam int LATENCY = 4;

    // Fields of ctrl_in
    localparam int CTRL_WE_BIT    = 1;
    localparam int CTRL_BURST_LSB = 2;

    // Fields of ctrl_out
    localparam int CTRL_WAIT_BIT = 0;

    typedef logic [BUS_W-1:0]      bus_word_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // Beat count of a burst is 2 to the power of the code
    typedef logic [2:0]            burst_code_t;

    // Wide enough for the last beat index of a code 7 burst
    typedef logic [7:0]            beat_count_t;
    typedef logic [3:0]            latency_count_t;

    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_READ_WAIT  = 3'd1,
        ST_WRITE_WAIT = 3'd2,
        ST_READ_DATA  = 3'd3,
        ST_WRITE_DATA = 3'd4,
        ST_FINISH     = 3'd5
    } acp_mem_state_t;

endpackage

//--- source/mem_port_if.sv
// Word memory port between the burst controller and the store
// Plain write strobe plus a combinational read of the addressed word

`timescale 1ns/1ps

interface mem_port_if import acp_mem_pkg::*; ();

    // Word address for both write and read
    mem_addr_t addr;

    // Write word and strobe, sampled at the rising clock edge
    bus_word_t wdata;
    logic      we;

    // Word currently stored at addr
    bus_word_t rdata;

    modport ctrl (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport store (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

//--- source/acp_mem_ctrl.sv
// ACP memory slave burst controller
// Latches the request in idle, waits a fixed latency with the host wait flag,
// then steps through 2^code beats on consecutive word addresses

`timescale 1ns/1ps

module acp_mem_ctrl
    import acp_mem_pkg::*;
(
    input  logic              clk,
    input  logic              latency_counter_reset,
    input  bus_word_t         bus_in,
    input  logic              ack,
    input  logic [CTRL_W-1:0] ctrl_in,
    output logic              wait_flag,
    output logic              rd_en,
    mem_port_if.ctrl          mem
);

    acp_mem_state_t state;
    acp_mem_state_t next_state;

    // Request fields captured while idle
    mem_addr_t      addr_cnt;
    burst_code_t    burst_code;
    logic           wr_flag;

    // Phase counters
    beat_count_t    beat_cnt;
    latency_count_t lat_cnt;

    // Decoded per-state controls
    logic           idle_load;
    logic           lat_en;
    logic           beat_en;
    logic           wr_beat;

    logic           lat_done;
    logic           beat_last;

    // Latency runs 0 .. LATENCY-1 across the wait state
    assign lat_done = (lat_cnt == latency_count_t'(LATENCY - 1));

    // Last beat index is 2^code - 1
    assign beat_last = (beat_cnt == ((beat_count_t'(1) << burst_code) - beat_count_t'(1)));

    always_ff @(posedge clk) begin
        if (latency_counter_reset) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Burst code and write flag follow ctrl_in until the request edge
    always_ff @(posedge clk) begin
        if (latency_counter_reset) begin
            burst_code <= '0;
            wr_flag    <= 1'b0;
        end else if (idle_load) begin
            burst_code <= ctrl_in[CTRL_BURST_LSB +: $bits(burst_code_t)];
            wr_flag    <= ctrl_in[CTRL_WE_BIT];
        end
    end

    // Start address from the bus, then one step per beat
    always_ff @(posedge clk) begin
        if (latency_counter_reset) begin
            addr_cnt <= '0;
        end else if (idle_load) begin
            addr_cnt <= bus_in[MEM_ADDR_W-1:0];
        end else if (beat_en) begin
            // Wraps at the memory size
            addr_cnt <= addr_cnt + mem_addr_t'(1);
        end
    end

    // Beat counter ends the data phase independently of the address
    always_ff @(posedge clk) begin
        if (latency_counter_reset) begin
            beat_cnt <= '0;
        end else if (idle_load) begin
            beat_cnt <= '0;
        end else if (beat_en) begin
            beat_cnt <= beat_cnt + beat_count_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (latency_counter_reset) begin
            lat_cnt <= '0;
        end else if (idle_load) begin
            lat_cnt <= '0;
        end else if (lat_en) begin
            lat_cnt <= lat_cnt + latency_count_t'(1);
        end
    end

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (ack) begin
                    if (ctrl_in[CTRL_WE_BIT]) begin
                        next_state = ST_WRITE_WAIT;
                    end else begin
                        next_state = ST_READ_WAIT;
                    end
                end
            end
            ST_READ_WAIT,
            ST_WRITE_WAIT: begin
                // Write flag was latched at the request edge
                if (lat_done) begin
                    if (wr_flag) begin
                        next_state = ST_WRITE_DATA;
                    end else begin
                        next_state = ST_READ_DATA;
                    end
                end
            end
            ST_READ_DATA,
            ST_WRITE_DATA: begin
                if (beat_last) begin
                    next_state = ST_FINISH;
                end
            end
            ST_FINISH: begin
                // Host releases ack to end the transaction
                if (!ack) begin
                    next_state = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // Outputs decoded from the current state
    always_comb begin
        idle_load = 1'b0;
        lat_en    = 1'b0;
        beat_en   = 1'b0;
        wr_beat   = 1'b0;
        rd_en     = 1'b0;
        wait_flag = 1'b0;
        case (state)
            ST_IDLE: begin
                idle_load = 1'b1;
            end
            ST_READ_WAIT,
            ST_WRITE_WAIT: begin
                lat_en = 1'b1;
                // Dropped one cycle before the first beat
                if (lat_cnt <= latency_count_t'(LATENCY - 2)) begin
                    wait_flag = 1'b1;
                end
            end
            ST_READ_DATA: begin
                beat_en = 1'b1;
                rd_en   = 1'b1;
            end
            ST_WRITE_DATA: begin
                beat_en = 1'b1;
                wr_beat = 1'b1;
            end
            default: begin
                idle_load = 1'b0;
            end
        endcase
    end

    // Memory port
    assign mem.addr  = addr_cnt;
    assign mem.wdata = bus_in;
    assign mem.we    = wr_beat;

endmodule

//--- source/acp_mem_store.sv
// ACP memory slave word store
// 64-word array with a synchronous write strobe and an asynchronous read,
// and the gating of the read word onto the host bus during read beats

`timescale 1ns/1ps

module acp_mem_store
    import acp_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rd_en,
    output bus_word_t bus_out,
    mem_port_if.store mem
);

    localparam int MEM_DEPTH = 1 << MEM_ADDR_W;

    // Contents are undefined until written
    bus_word_t mem_q [MEM_DEPTH];

    // Write beat stores the bus word at the current address
    always_ff @(posedge clk) begin
        if (mem.we) begin
            mem_q[mem.addr] <= mem.wdata;
        end
    end

    // Addressed word, visible in the same cycle
    assign mem.rdata = mem_q[mem.addr];

    // Bus stays at zero outside read beats
    always_comb begin
        if (rd_en) begin
            bus_out = mem.rdata;
        end else begin
            bus_out = '0;
        end
    end

endmodule

//--- source/acp_mem_top.sv
// ACP memory-side bus slave top level
// Burst controller and word store on a shared memory port, with the
// host bus brought out as plain ports and the wait flag on ctrl_out

`timescale 1ns/1ps

module acp_mem_top
    import acp_mem_pkg::*;
(
    input  logic              clk,
    input  logic              latency_counter_reset,
    input  bus_word_t         bus_in,
    input  logic              ack,
    input  logic [CTRL_W-1:0] ctrl_in,
    output logic [CTRL_W-1:0] ctrl_out,
    output bus_word_t         bus_out
);

    logic wait_flag;
    logic rd_en;

    mem_port_if i_mem_port ();

    acp_mem_ctrl i_acp_mem_ctrl (
        .clk                   (clk),
        .latency_counter_reset (latency_counter_reset),
        .bus_in                (bus_in),
        .ack                   (ack),
        .ctrl_in               (ctrl_in),
        .wait_flag             (wait_flag),
        .rd_en                 (rd_en),
        .mem                   (i_mem_port.ctrl)
    );

    acp_mem_store i_acp_mem_store (
        .clk     (clk),
        .rd_en   (rd_en),
        .bus_out (bus_out),
        .mem     (i_mem_port.store)
    );

    // Only the wait flag is defined on ctrl_out
    always_comb begin
        ctrl_out                = '0;
        ctrl_out[CTRL_WAIT_BIT] = wait_flag;
    end

endmodule

//--- test/acp_mem_asserts.sv
// Protocol assertions for the ACP memory burst controller
// Bound into the controller to relate its state to its outputs

`timescale 1ns/1ps

module acp_mem_asserts import acp_mem_pkg::*; (
    input logic           clk,
    input logic           latency_counter_reset,
    input logic           ack,
    input acp_mem_state_t state,
    input logic           wait_flag,
    input logic           we
);

    int fail_count = 0;

    // Wait flag belongs to the latency phase only
    a_wait_in_wait_state: assert property (@(posedge clk) disable iff (latency_counter_reset)
        wait_flag |-> (state inside {ST_READ_WAIT, ST_WRITE_WAIT}))
    else begin
        fail_count++;
        $error("wait flag high outside a wait state");
    end

    a_we_in_write_data: assert property (@(posedge clk) disable iff (latency_counter_reset)
        we |-> (state == ST_WRITE_DATA))
    else begin
        fail_count++;
        $error("memory write strobe outside a write beat");
    end

    a_idle_after_reset: assert property (@(posedge clk)
        latency_counter_reset |=> (state == ST_IDLE))
    else begin
        fail_count++;
        $error("state is not idle after reset");
    end

    // Host keeps the slave parked in finish until ack falls
    a_finish_holds: assert property (@(posedge clk) disable iff (latency_counter_reset)
        (state == ST_FINISH && ack) |=> (state == ST_FINISH))
    else begin
        fail_count++;
        $error("finish state left while ack was high");
    end

endmodule

//--- test/acp_mem_checker.sv
// Burst monitor for the ACP memory slave
// Follows each burst at the host ports, keeps a model of the word memory
// and compares the wait flag and bus_out with the expected values

`timescale 1ns/1ps

module acp_mem_checker import acp_mem_pkg::*; (
    input  logic              clk,
    input  logic              latency_counter_reset,
    input  bus_word_t         bus_in,
    input  logic              ack,
    input  logic [CTRL_W-1:0] ctrl_in,
    input  logic [CTRL_W-1:0] ctrl_out,
    input  bus_word_t         bus_out,
    output int                error_count,
    output int                read_checks
);

    typedef enum logic [1:0] {M_IDLE, M_WAIT, M_DATA, M_FINISH} phase_t;

    phase_t    phase = M_IDLE;
    bus_word_t model_mem [1 << MEM_ADDR_W];
    mem_addr_t start_addr;
    int        code;
    logic      wr;
    int        wait_cnt;
    int        beat;

    initial begin
        error_count = 0;
        read_checks = 0;
    end

    // Expected read word at a memory address
    function automatic bus_word_t expected_word(input mem_addr_t addr);
        return model_mem[addr];
    endfunction

    task automatic report_value(input string sig, input bus_word_t exp, input bus_word_t got);
        $display("[ERROR] %0t ns %s expected %h got %h", $time, sig, exp, got);
        error_count++;
    endtask

    // Sampled mid-cycle where inputs hold what the next rising edge will see
    always @(negedge clk) begin
        mem_addr_t         a;
        logic [CTRL_W-1:0] exp_ctrl;
        if (latency_counter_reset) begin
            phase = M_IDLE;
        end else begin
            // First LATENCY-1 wait cycles raise the flag, other bits stay low
            exp_ctrl                = '0;
            exp_ctrl[CTRL_WAIT_BIT] = (phase == M_WAIT) && (wait_cnt < LATENCY - 1);
            if (ctrl_out !== exp_ctrl) begin
                report_value("ctrl_out", bus_word_t'(exp_ctrl), bus_word_t'(ctrl_out));
            end
            a = start_addr + mem_addr_t'(beat);
            if (phase == M_DATA && !wr) begin
                read_checks++;
                if (bus_out !== expected_word(a)) begin
                    report_value("bus_out", expected_word(a), bus_out);
                end
            end else if (bus_out !== '0) begin
                report_value("bus_out", '0, bus_out);
            end
            case (phase)
                M_IDLE: begin
                    if (ack === 1'b1) begin
                        start_addr = bus_in[MEM_ADDR_W-1:0];
                        code       = int'(ctrl_in[CTRL_BURST_LSB +: 3]);
                        wr         = ctrl_in[CTRL_WE_BIT];
                        wait_cnt   = 0;
                        beat       = 0;
                        phase      = M_WAIT;
                    end
                end
                M_WAIT: begin
                    wait_cnt++;
                    if (wait_cnt == LATENCY) begin
                        phase = M_DATA;
                    end
                end
                M_DATA: begin
                    if (wr) begin
                        model_mem[a] = bus_in;
                    end
                    beat++;
                    if (beat == (1 << code)) begin
                        phase = M_FINISH;
                    end
                end
                default: begin
                    if (ack === 1'b0) begin
                        phase = M_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- test/tb_acp_mem.sv
// Testbench for the ACP memory-side bus slave
// Runs directed and random bursts on the host bus, the checker compares
// every cycle, and each test reports as it finishes

`timescale 1ns/1ps

module tb_acp_mem import acp_mem_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int IDLE_GAP     = 2;
    localparam int N_BURSTS     = 31;
    // Request cycle, latency, 8 beats, hold up to 5, ack drop, gap
    localparam int BURST_CYCLES   = 1 + LATENCY + 8 + 5 + 1 + IDLE_GAP;
    localparam int PRELOAD_CYCLES = 1 + LATENCY + 64 + 1 + IDLE_GAP;
    localparam int MAX_CYCLES     = RESET_CYCLES + PRELOAD_CYCLES
                                    + N_BURSTS * BURST_CYCLES + 100;

    logic              clk;
    logic              latency_counter_reset;
    bus_word_t         bus_in;
    logic              ack;
    logic [CTRL_W-1:0] ctrl_in;
    logic [CTRL_W-1:0] ctrl_out;
    bus_word_t         bus_out;

    int        checker_errors;
    int        read_checks;
    int        test_num;
    int        tests_failed;
    int        errors_before;
    int        cycle_cnt;
    bus_word_t lcg_state;

    acp_mem_top i_acp_mem_top (
        .clk                   (clk),
        .latency_counter_reset (latency_counter_reset),
        .bus_in                (bus_in),
        .ack                   (ack),
        .ctrl_in               (ctrl_in),
        .ctrl_out              (ctrl_out),
        .bus_out               (bus_out)
    );

    acp_mem_checker i_acp_mem_checker (
        .clk                   (clk),
        .latency_counter_reset (latency_counter_reset),
        .bus_in                (bus_in),
        .ack                   (ack),
        .ctrl_in               (ctrl_in),
        .ctrl_out              (ctrl_out),
        .bus_out               (bus_out),
        .error_count           (checker_errors),
        .read_checks           (read_checks)
    );

    bind acp_mem_ctrl acp_mem_asserts i_acp_mem_asserts (
        .clk                   (clk),
        .latency_counter_reset (latency_counter_reset),
        .ack                   (ack),
        .state                 (state),
        .wait_flag             (wait_flag),
        .we                    (wr_beat)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic bus_word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int total_errors();
        return checker_errors + i_acp_mem_top.i_acp_mem_ctrl.i_acp_mem_asserts.fail_count;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // One request with the fixed latency, then the beats and the ack release
    task automatic run_burst(input logic wr, input int code, input int addr, input int hold);
        ack                          = 1'b1;
        bus_in                       = bus_word_t'(addr);
        ctrl_in                      = '0;
        ctrl_in[CTRL_WE_BIT]         = wr;
        ctrl_in[CTRL_BURST_LSB +: 3] = code[2:0];
        next_cycle();
        bus_in = '0;
        repeat (LATENCY) next_cycle();
        for (int k = 0; k < (1 << code); k++) begin
            if (wr) begin
                bus_in = next_rand();
            end
            next_cycle();
        end
        bus_in = '0;
        repeat (hold) next_cycle();
        ack     = 1'b0;
        ctrl_in = '0;
        next_cycle();
        repeat (IDLE_GAP) next_cycle();
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = total_errors() - errors_before;
        test_num++;
        if (errs == 0) begin
            $display("test %0d %s: pass", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", test_num, name, errs);
        end
        errors_before = total_errors();
    endtask

    initial begin
        bus_word_t r;
        latency_counter_reset = 1'b1;
        bus_in                = '0;
        ack                   = 1'b0;
        ctrl_in               = '0;
        lcg_state             = 32'h51d6;
        test_num              = 0;
        tests_failed          = 0;
        errors_before         = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        latency_counter_reset = 1'b0;
        next_cycle();

        // Every word gets a known value before any read
        run_burst(1'b1, 6, 0, 0);
        end_test("preload fill");
        run_burst(1'b1, 0, 17, 0);
        run_burst(1'b0, 0, 17, 0);
        end_test("single word write and read");
        run_burst(1'b0, 1, 5, 1);
        end_test("wait flag timing");
        run_burst(1'b1, 2, 8, 0);
        run_burst(1'b0, 2, 8, 0);
        run_burst(1'b1, 3, 30, 1);
        run_burst(1'b0, 3, 30, 0);
        end_test("bursts of 4 and 8 beats");
        run_burst(1'b1, 3, 60, 0);
        run_burst(1'b0, 3, 60, 0);
        end_test("address wrap");
        run_burst(1'b1, 1, 40, 5);
        run_burst(1'b0, 1, 40, 0);
        end_test("ack held after burst");
        for (int i = 0; i < 20; i++) begin
            r = next_rand();
            run_burst(r[31], int'(r[29:28]), int'(r[21:16]), int'(r[25:24]));
        end
        end_test("random bursts");

        $display("%0d tests run, %0d failed, %0d read beats checked, %0d errors",
                 test_num, tests_failed, read_checks, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run did not finish within %0d cycles", MAX_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- filelist.f
source/acp_mem_pkg.sv
source/mem_port_if.sv
source/acp_mem_ctrl.sv
source/acp_mem_store.sv
source/acp_mem_top.sv
test/acp_mem_asserts.sv
test/acp_mem_checker.sv
test/tb_acp_mem.sv
